// File: files.f
logic/isa_pkg.sv
logic/alu_pkg.sv
logic/rtype_decode.sv
logic/itype_decode.sv
logic/decode_merge.sv
logic/operand_select.sv
logic/id_stage.sv
tests/id_stage_tb.sv

// File: logic/alu_pkg.sv
package alu_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;

    localparam int ALUOP_W = 8;
    localparam int ALUSEL_W = 3;

    typedef logic [ALUOP_W-1:0] aluop_t;
    typedef logic [ALUSEL_W-1:0] alusel_t;

    // ALU operations, low bits follow the function code where one exists
    localparam aluop_t ALUOP_NOP = 8'b0000_0000;
    localparam aluop_t ALUOP_AND = 8'b0010_0100;
    localparam aluop_t ALUOP_OR = 8'b0010_0101;
    localparam aluop_t ALUOP_XOR = 8'b0010_0110;
    localparam aluop_t ALUOP_NOR = 8'b0010_0111;
    localparam aluop_t ALUOP_SLL = 8'b0111_1100;
    localparam aluop_t ALUOP_SRL = 8'b0000_0010;
    localparam aluop_t ALUOP_SRA = 8'b0000_0011;
    localparam aluop_t ALUOP_MOVZ = 8'b0000_1010;
    localparam aluop_t ALUOP_MOVN = 8'b0000_1011;

    // Result select for the execute stage
    localparam alusel_t SEL_NOP = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_MOVE = 3'b011;

endpackage

// File: logic/decode_merge.sv
module decode_merge (
    input  logic                        rst_n,
    input  isa_pkg::inst_word_u         inst,
    input  logic                        rtype_hit,
    input  logic                        rtype_rd_en1,
    input  logic                        rtype_rd_en2,
    input  logic                        rtype_wr_en,
    input  logic                        rtype_is_move,
    input  logic                        rtype_is_movn,
    input  alu_pkg::aluop_t             rtype_aluop,
    input  alu_pkg::alusel_t            rtype_alusel,
    input  logic [alu_pkg::DATA_W-1:0]  rtype_imm,
    input  logic                        itype_hit,
    input  logic                        itype_rd_en1,
    input  logic                        itype_wr_en,
    input  alu_pkg::aluop_t             itype_aluop,
    input  alu_pkg::alusel_t            itype_alusel,
    input  logic [alu_pkg::DATA_W-1:0]  itype_imm,
    input  logic [alu_pkg::DATA_W-1:0]  operand1,
    output logic [alu_pkg::ADDR_W-1:0]  rd_addr1,
    output logic [alu_pkg::ADDR_W-1:0]  rd_addr2,
    output logic [alu_pkg::ADDR_W-1:0]  wr_addr,
    output logic                        rd_en1,
    output logic                        rd_en2,
    output logic                        wr_en,
    output alu_pkg::aluop_t             aluop,
    output alu_pkg::alusel_t            alusel,
    output logic [alu_pkg::DATA_W-1:0]  imm
);

    logic move_wr;

    always_comb begin
        rd_addr1 = '0;
        rd_addr2 = '0;
        wr_addr = '0;
        rd_en1 = 1'b0;
        rd_en2 = 1'b0;
        aluop = alu_pkg::ALUOP_NOP;
        alusel = alu_pkg::SEL_NOP;
        imm = '0;
        if (rst_n) begin
            rd_addr1 = inst.r.rs;
            rd_addr2 = inst.r.rt;
            wr_addr = inst.r.rd;                                // rd unless an immediate op hit
            if (rtype_hit) begin
                rd_en1 = rtype_rd_en1;
                rd_en2 = rtype_rd_en2;
                aluop = rtype_aluop;
                alusel = rtype_alusel;
                imm = rtype_imm;
            end else if (itype_hit) begin
                wr_addr = inst.i.rt;
                rd_en1 = itype_rd_en1;
                aluop = itype_aluop;
                alusel = itype_alusel;
                imm = itype_imm;
            end
        end
    end

    // MOVN writes on nonzero rs, MOVZ on zero
    assign move_wr = rtype_is_movn ? (operand1 != '0) : (operand1 == '0);

    always_comb begin
        if (!rst_n) begin
            wr_en = 1'b0;
        end else if (rtype_hit) begin
            wr_en = rtype_is_move ? move_wr : rtype_wr_en;
        end else begin
            wr_en = itype_hit && itype_wr_en;
        end
    end

endmodule

// File: logic/id_stage.sv
module id_stage (
    input  logic                         rst_n,
    input  logic [isa_pkg::INST_W-1:0]   inst_data,
    input  logic [alu_pkg::DATA_W-1:0]   reg_rd_data1,
    input  logic [alu_pkg::DATA_W-1:0]   reg_rd_data2,
    input  logic [alu_pkg::ADDR_W-1:0]   ex_waddr,
    input  logic [alu_pkg::DATA_W-1:0]   ex_wdata,
    input  logic                         ex_wen,
    input  logic [alu_pkg::ADDR_W-1:0]   mem_waddr,
    input  logic [alu_pkg::DATA_W-1:0]   mem_wdata,
    input  logic                         mem_wen,
    output logic [alu_pkg::ADDR_W-1:0]   reg_rd_addr1,
    output logic [alu_pkg::ADDR_W-1:0]   reg_rd_addr2,
    output logic                         reg_rd_en1,
    output logic                         reg_rd_en2,
    output logic [alu_pkg::ADDR_W-1:0]   reg_wr_addr,
    output logic                         reg_wr_en,
    output logic [alu_pkg::DATA_W-1:0]   operand1,
    output logic [alu_pkg::DATA_W-1:0]   operand2,
    output alu_pkg::aluop_t              aluop,
    output alu_pkg::alusel_t             alusel
);

    logic                       rtype_hit;
    logic                       rtype_rd_en1;
    logic                       rtype_rd_en2;
    logic                       rtype_wr_en;
    logic                       rtype_is_move;
    logic                       rtype_is_movn;
    alu_pkg::aluop_t            rtype_aluop;
    alu_pkg::alusel_t           rtype_alusel;
    logic [alu_pkg::DATA_W-1:0] rtype_imm;

    logic                       itype_hit;
    logic                       itype_rd_en1;
    logic                       itype_wr_en;
    alu_pkg::aluop_t            itype_aluop;
    alu_pkg::alusel_t           itype_alusel;
    logic [alu_pkg::DATA_W-1:0] itype_imm;

    logic [alu_pkg::DATA_W-1:0] imm;

    rtype_decode u_rtype (
        .inst    (inst_data),
        .hit     (rtype_hit),
        .rd_en1  (rtype_rd_en1),
        .rd_en2  (rtype_rd_en2),
        .wr_en   (rtype_wr_en),
        .is_move (rtype_is_move),
        .is_movn (rtype_is_movn),
        .aluop   (rtype_aluop),
        .alusel  (rtype_alusel),
        .imm     (rtype_imm)
    );

    itype_decode u_itype (
        .inst   (inst_data),
        .hit    (itype_hit),
        .rd_en1 (itype_rd_en1),
        .wr_en  (itype_wr_en),
        .aluop  (itype_aluop),
        .alusel (itype_alusel),
        .imm    (itype_imm)
    );

    decode_merge u_merge (
        .rst_n         (rst_n),
        .inst          (inst_data),
        .rtype_hit     (rtype_hit),
        .rtype_rd_en1  (rtype_rd_en1),
        .rtype_rd_en2  (rtype_rd_en2),
        .rtype_wr_en   (rtype_wr_en),
        .rtype_is_move (rtype_is_move),
        .rtype_is_movn (rtype_is_movn),
        .rtype_aluop   (rtype_aluop),
        .rtype_alusel  (rtype_alusel),
        .rtype_imm     (rtype_imm),
        .itype_hit     (itype_hit),
        .itype_rd_en1  (itype_rd_en1),
        .itype_wr_en   (itype_wr_en),
        .itype_aluop   (itype_aluop),
        .itype_alusel  (itype_alusel),
        .itype_imm     (itype_imm),
        .operand1      (operand1),                              // Feeds the MOVN/MOVZ test
        .rd_addr1      (reg_rd_addr1),
        .rd_addr2      (reg_rd_addr2),
        .wr_addr       (reg_wr_addr),
        .rd_en1        (reg_rd_en1),
        .rd_en2        (reg_rd_en2),
        .wr_en         (reg_wr_en),
        .aluop         (aluop),
        .alusel        (alusel),
        .imm           (imm)
    );

    operand_select #(
        .DATA_W (alu_pkg::DATA_W),
        .ADDR_W (alu_pkg::ADDR_W)
    ) u_operand1 (
        .rst_n     (rst_n),
        .rd_en     (reg_rd_en1),
        .rd_addr   (reg_rd_addr1),
        .reg_data  (reg_rd_data1),
        .imm       (imm),
        .ex_waddr  (ex_waddr),
        .ex_wdata  (ex_wdata),
        .ex_wen    (ex_wen),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .operand   (operand1)
    );

    operand_select #(
        .DATA_W (alu_pkg::DATA_W),
        .ADDR_W (alu_pkg::ADDR_W)
    ) u_operand2 (
        .rst_n     (rst_n),
        .rd_en     (reg_rd_en2),
        .rd_addr   (reg_rd_addr2),
        .reg_data  (reg_rd_data2),
        .imm       (imm),
        .ex_waddr  (ex_waddr),
        .ex_wdata  (ex_wdata),
        .ex_wen    (ex_wen),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .operand   (operand2)
    );

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

    localparam int INST_W = 32;
    localparam int OP_W = 6;
    localparam int FUNCT_W = 6;
    localparam int REG_FIELD_W = 5;
    localparam int SHAMT_W = 5;
    localparam int IMM_W = 16;

    typedef logic [OP_W-1:0] op_t;
    typedef logic [FUNCT_W-1:0] funct_t;

    // Primary opcodes
    localparam op_t OP_SPECIAL = 6'd0;
    localparam op_t OP_ANDI = 6'd12;
    localparam op_t OP_ORI = 6'd13;
    localparam op_t OP_XORI = 6'd14;
    localparam op_t OP_LUI = 6'd15;
    localparam op_t OP_PREF = 6'd51;

    // SPECIAL function codes
    localparam funct_t FN_SLL = 6'd0;
    localparam funct_t FN_SRL = 6'd2;
    localparam funct_t FN_SRA = 6'd3;
    localparam funct_t FN_SLLV = 6'd4;
    localparam funct_t FN_SRLV = 6'd6;
    localparam funct_t FN_SRAV = 6'd7;
    localparam funct_t FN_MOVZ = 6'd10;
    localparam funct_t FN_MOVN = 6'd11;
    localparam funct_t FN_SYNC = 6'd15;
    localparam funct_t FN_AND = 6'd36;
    localparam funct_t FN_OR = 6'd37;
    localparam funct_t FN_XOR = 6'd38;
    localparam funct_t FN_NOR = 6'd39;

    typedef struct packed {
        op_t                    op;
        logic [REG_FIELD_W-1:0] rs;
        logic [REG_FIELD_W-1:0] rt;
        logic [REG_FIELD_W-1:0] rd;
        logic [SHAMT_W-1:0]     shamt;
        funct_t                 funct;
    } r_fmt_t;

    typedef struct packed {
        op_t                    op;
        logic [REG_FIELD_W-1:0] rs;
        logic [REG_FIELD_W-1:0] rt;
        logic [IMM_W-1:0]       imm;
    } i_fmt_t;

    // Same 32 bits, register or immediate layout
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

endpackage

// File: logic/itype_decode.sv
module itype_decode (
    input  isa_pkg::inst_word_u         inst,
    output logic                        hit,
    output logic                        rd_en1,
    output logic                        wr_en,
    output alu_pkg::aluop_t             aluop,
    output alu_pkg::alusel_t            alusel,
    output logic [alu_pkg::DATA_W-1:0]  imm
);

    localparam int PAD_W = alu_pkg::DATA_W - isa_pkg::IMM_W;

    logic [alu_pkg::DATA_W-1:0] imm_low;
    logic [alu_pkg::DATA_W-1:0] imm_high;

    assign imm_low = {{PAD_W{1'b0}}, inst.i.imm};
    assign imm_high = {inst.i.imm, {PAD_W{1'b0}}};

    always_comb begin
        hit = 1'b1;
        rd_en1 = 1'b1;                                          // rs against the immediate
        wr_en = 1'b1;
        aluop = alu_pkg::ALUOP_NOP;
        alusel = alu_pkg::SEL_LOGIC;
        imm = imm_low;
        case (inst.i.op)
            isa_pkg::OP_ORI: begin
                aluop = alu_pkg::ALUOP_OR;
            end
            isa_pkg::OP_ANDI: begin
                aluop = alu_pkg::ALUOP_AND;
            end
            isa_pkg::OP_XORI: begin
                aluop = alu_pkg::ALUOP_XOR;
            end
            isa_pkg::OP_LUI: begin
                aluop = alu_pkg::ALUOP_OR;
                imm = imm_high;
            end
            isa_pkg::OP_PREF: begin
                rd_en1 = 1'b0;                                  // Prefetch hint, nothing to do
                wr_en = 1'b0;
                imm = '0;
            end
            default: begin
                hit = 1'b0;
                rd_en1 = 1'b0;
                wr_en = 1'b0;
                alusel = alu_pkg::SEL_NOP;
                imm = '0;
            end
        endcase
    end

endmodule

// File: logic/operand_select.sv
module operand_select #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 5
) (
    input  logic              rst_n,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic [DATA_W-1:0] reg_data,
    input  logic [DATA_W-1:0] imm,
    input  logic [ADDR_W-1:0] ex_waddr,
    input  logic [DATA_W-1:0] ex_wdata,
    input  logic              ex_wen,
    input  logic [ADDR_W-1:0] mem_waddr,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic              mem_wen,
    output logic [DATA_W-1:0] operand
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit = rd_en && ex_wen && (rd_addr == ex_waddr);
    assign mem_hit = rd_en && mem_wen && (rd_addr == mem_waddr);

    // Youngest result wins
    always_comb begin
        if (!rst_n) begin
            operand = '0;
        end else if (ex_hit) begin
            operand = ex_wdata;
        end else if (mem_hit) begin
            operand = mem_wdata;
        end else if (rd_en) begin
            operand = reg_data;
        end else begin
            operand = imm;                                      // Port unused, carry the immediate
        end
    end

endmodule

// File: logic/rtype_decode.sv
module rtype_decode (
    input  isa_pkg::inst_word_u         inst,
    output logic                        hit,
    output logic                        rd_en1,
    output logic                        rd_en2,
    output logic                        wr_en,
    output logic                        is_move,
    output logic                        is_movn,
    output alu_pkg::aluop_t             aluop,
    output alu_pkg::alusel_t            alusel,
    output logic [alu_pkg::DATA_W-1:0]  imm
);

    logic shift_imm;

    // Shift amount comes from the shamt field, rs must be zero
    assign shift_imm = (inst.r.rs == '0) &&
                       ((inst.r.funct == isa_pkg::FN_SLL) ||
                        (inst.r.funct == isa_pkg::FN_SRL) ||
                        (inst.r.funct == isa_pkg::FN_SRA));

    always_comb begin
        hit = 1'b0;
        rd_en1 = 1'b0;
        rd_en2 = 1'b0;
        wr_en = 1'b0;
        is_move = 1'b0;
        is_movn = 1'b0;
        aluop = alu_pkg::ALUOP_NOP;
        alusel = alu_pkg::SEL_NOP;
        imm = '0;
        if (inst.r.op == isa_pkg::OP_SPECIAL) begin
            if (shift_imm) begin
                hit = 1'b1;
                rd_en2 = 1'b1;                                  // Shifted value from rt
                wr_en = 1'b1;
                alusel = alu_pkg::SEL_SHIFT;
                imm = {{(alu_pkg::DATA_W-isa_pkg::SHAMT_W){1'b0}}, inst.r.shamt};
                case (inst.r.funct)
                    isa_pkg::FN_SRL: aluop = alu_pkg::ALUOP_SRL;
                    isa_pkg::FN_SRA: aluop = alu_pkg::ALUOP_SRA;
                    default:         aluop = alu_pkg::ALUOP_SLL;
                endcase
            end else if (inst.r.shamt == '0) begin
                hit = 1'b1;
                rd_en1 = 1'b1;
                rd_en2 = 1'b1;
                wr_en = 1'b1;
                case (inst.r.funct)
                    isa_pkg::FN_OR: begin
                        aluop = alu_pkg::ALUOP_OR;
                        alusel = alu_pkg::SEL_LOGIC;
                    end
                    isa_pkg::FN_AND: begin
                        aluop = alu_pkg::ALUOP_AND;
                        alusel = alu_pkg::SEL_LOGIC;
                    end
                    isa_pkg::FN_XOR: begin
                        aluop = alu_pkg::ALUOP_XOR;
                        alusel = alu_pkg::SEL_LOGIC;
                    end
                    isa_pkg::FN_NOR: begin
                        aluop = alu_pkg::ALUOP_NOR;
                        alusel = alu_pkg::SEL_LOGIC;
                    end
                    isa_pkg::FN_SLLV: begin
                        aluop = alu_pkg::ALUOP_SLL;
                        alusel = alu_pkg::SEL_SHIFT;
                    end
                    isa_pkg::FN_SRLV: begin
                        aluop = alu_pkg::ALUOP_SRL;
                        alusel = alu_pkg::SEL_SHIFT;
                    end
                    isa_pkg::FN_SRAV: begin
                        aluop = alu_pkg::ALUOP_SRA;
                        alusel = alu_pkg::SEL_SHIFT;
                    end
                    isa_pkg::FN_MOVN: begin
                        aluop = alu_pkg::ALUOP_MOVN;
                        alusel = alu_pkg::SEL_MOVE;
                        is_move = 1'b1;                         // Write decided from rs value
                        is_movn = 1'b1;
                    end
                    isa_pkg::FN_MOVZ: begin
                        aluop = alu_pkg::ALUOP_MOVZ;
                        alusel = alu_pkg::SEL_MOVE;
                        is_move = 1'b1;
                    end
                    isa_pkg::FN_SYNC: begin
                        rd_en1 = 1'b0;                          // Treated as a no-op
                        wr_en = 1'b0;
                    end
                    default: begin
                        hit = 1'b0;
                        rd_en1 = 1'b0;
                        rd_en2 = 1'b0;
                        wr_en = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the decode-stage testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module id_stage_tb -f files.f -o id_stage_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/id_stage_sim > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation did not finish, see sim.log"; exit 1; }
echo "Simulation passed"

// File: tests/id_stage_tb.sv
module id_stage_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY = 2;
    localparam int SAMPLE_DLY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = 200;                        // About four times the test length
    localparam logic [31:0] SEED = 32'h610f8386;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           inst_data;
    logic [31:0]           reg_rd_data1;
    logic [31:0]           reg_rd_data2;
    logic [4:0]            ex_waddr;
    logic [31:0]           ex_wdata;
    logic                  ex_wen;
    logic [4:0]            mem_waddr;
    logic [31:0]           mem_wdata;
    logic                  mem_wen;
    logic [4:0]            reg_rd_addr1;
    logic [4:0]            reg_rd_addr2;
    logic                  reg_rd_en1;
    logic                  reg_rd_en2;
    logic [4:0]            reg_wr_addr;
    logic                  reg_wr_en;
    logic [31:0]           operand1;
    logic [31:0]           operand2;
    alu_pkg::aluop_t       aluop;
    alu_pkg::alusel_t      alusel;
    int                    cycle_count = 0;

    id_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests were still running after %0d clock cycles",
                     TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs(logic [4:0] addr1, logic [4:0] addr2, logic en1, logic en2,
                                 logic [4:0] waddr, logic wen, logic [31:0] op1,
                                 logic [31:0] op2, alu_pkg::aluop_t op,
                                 alu_pkg::alusel_t sel);
        check_value("reg_rd_addr1", 32'(reg_rd_addr1), 32'(addr1));
        check_value("reg_rd_addr2", 32'(reg_rd_addr2), 32'(addr2));
        check_value("reg_rd_en1", 32'(reg_rd_en1), 32'(en1));
        check_value("reg_rd_en2", 32'(reg_rd_en2), 32'(en2));
        check_value("reg_wr_addr", 32'(reg_wr_addr), 32'(waddr));
        check_value("reg_wr_en", 32'(reg_wr_en), 32'(wen));
        check_value("operand1", operand1, op1);
        check_value("operand2", operand2, op2);
        check_value("aluop", 32'(aluop), 32'(op));
        check_value("alusel", 32'(alusel), 32'(sel));
    endtask

    function automatic logic [31:0] r_format(isa_pkg::op_t op, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] shamt,
                                             isa_pkg::funct_t fn);
        return {op, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] i_format(isa_pkg::op_t op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Inputs change shortly after the edge, outputs are sampled before the next one
    task automatic apply_inputs(logic [31:0] inst, logic [31:0] d1, logic [31:0] d2,
                                logic [4:0] ex_a, logic [31:0] ex_d, logic ex_e,
                                logic [4:0] mem_a, logic [31:0] mem_d, logic mem_e);
        @(posedge clk);
        #DRIVE_DLY;
        inst_data = inst;
        reg_rd_data1 = d1;
        reg_rd_data2 = d2;
        ex_waddr = ex_a;
        ex_wdata = ex_d;
        ex_wen = ex_e;
        mem_waddr = mem_a;
        mem_wdata = mem_d;
        mem_wen = mem_e;
        #SAMPLE_DLY;
    endtask

    task automatic apply_without_forwarding(logic [31:0] inst, logic [31:0] d1, logic [31:0] d2);
        apply_inputs(inst, d1, d2, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b0);
    endtask

    // Forwarding stays active so reset must override it
    task automatic reset_behavior(int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            rst_n = 1'b0;
            inst_data = (i % 2 == 0) ?
                        r_format(isa_pkg::OP_SPECIAL, 5'(i), 5'(i + 1), 5'(i + 2), 5'd0,
                                 isa_pkg::FN_OR) :
                        i_format(isa_pkg::OP_LUI, 5'(i), 5'(i + 3), 16'(i * 16'h0101));
            reg_rd_data1 = $urandom;
            reg_rd_data2 = $urandom;
            ex_waddr = 5'(i);
            ex_wdata = $urandom;
            ex_wen = 1'b1;
            mem_waddr = 5'(i + 1);
            mem_wdata = $urandom;
            mem_wen = 1'b1;
            #SAMPLE_DLY;
            check_outputs('0, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0, alu_pkg::ALUOP_NOP,
                          alu_pkg::SEL_NOP);
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
    endtask

    task automatic rtype_case(isa_pkg::funct_t fn, alu_pkg::aluop_t op, alu_pkg::alusel_t sel);
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = $urandom;
        d2 = $urandom;
        apply_without_forwarding(r_format(isa_pkg::OP_SPECIAL, 5'd9, 5'd17, 5'd30, 5'd0, fn),
                                 d1, d2);
        check_outputs(5'd9, 5'd17, 1'b1, 1'b1, 5'd30, 1'b1, d1, d2, op, sel);
    endtask

    task automatic imm_logic_case(isa_pkg::op_t opc, alu_pkg::aluop_t op, logic [15:0] imm,
                                  logic [31:0] exp_op2);
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = $urandom;
        d2 = $urandom;
        apply_without_forwarding(i_format(opc, 5'd4, 5'd12, imm), d1, d2);
        check_outputs(5'd4, 5'd12, 1'b1, 1'b0, 5'd12, 1'b1, d1, exp_op2, op,
                      alu_pkg::SEL_LOGIC);
    endtask

    task automatic shift_imm_case(isa_pkg::funct_t fn, alu_pkg::aluop_t op, logic [4:0] shamt);
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = $urandom;
        d2 = $urandom;
        apply_without_forwarding(r_format(isa_pkg::OP_SPECIAL, 5'd0, 5'd21, 5'd22, shamt, fn),
                                 d1, d2);
        check_outputs(5'd0, 5'd21, 1'b0, 1'b1, 5'd22, 1'b1, {27'd0, shamt}, d2, op,
                      alu_pkg::SEL_SHIFT);
    endtask

    task automatic forwarding_priority();
        logic [31:0] inst;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] ex_d;
        logic [31:0] mem_d;
        inst = r_format(isa_pkg::OP_SPECIAL, 5'd3, 5'd4, 5'd5, 5'd0, isa_pkg::FN_OR);
        d1 = $urandom;
        d2 = $urandom;
        ex_d = $urandom;
        mem_d = $urandom;
        apply_inputs(inst, d1, d2, 5'd3, ex_d, 1'b1, 5'd3, mem_d, 1'b1);  // ex is younger
        check_outputs(5'd3, 5'd4, 1'b1, 1'b1, 5'd5, 1'b1, ex_d, d2, alu_pkg::ALUOP_OR,
                      alu_pkg::SEL_LOGIC);
        apply_inputs(inst, d1, d2, 5'd9, ex_d, 1'b1, 5'd4, mem_d, 1'b1);
        check_outputs(5'd3, 5'd4, 1'b1, 1'b1, 5'd5, 1'b1, d1, mem_d, alu_pkg::ALUOP_OR,
                      alu_pkg::SEL_LOGIC);
        apply_inputs(inst, d1, d2, 5'd4, ex_d, 1'b0, 5'd4, mem_d, 1'b1);  // ex not writing
        check_outputs(5'd3, 5'd4, 1'b1, 1'b1, 5'd5, 1'b1, d1, mem_d, alu_pkg::ALUOP_OR,
                      alu_pkg::SEL_LOGIC);
        apply_inputs(inst, d1, d2, 5'd3, ex_d, 1'b0, 5'd3, mem_d, 1'b0);
        check_outputs(5'd3, 5'd4, 1'b1, 1'b1, 5'd5, 1'b1, d1, d2, alu_pkg::ALUOP_OR,
                      alu_pkg::SEL_LOGIC);
        // Register 0 forwards like any other
        apply_inputs(r_format(isa_pkg::OP_SPECIAL, 5'd0, 5'd0, 5'd5, 5'd0, isa_pkg::FN_XOR),
                     d1, d2, 5'd0, ex_d, 1'b1, 5'd0, mem_d, 1'b1);
        check_outputs(5'd0, 5'd0, 1'b1, 1'b1, 5'd5, 1'b1, ex_d, ex_d, alu_pkg::ALUOP_XOR,
                      alu_pkg::SEL_LOGIC);
        // Port 2 is off for ORI, so the rt match must not show
        apply_inputs(i_format(isa_pkg::OP_ORI, 5'd3, 5'd4, 16'h00a5), d1, d2,
                     5'd4, ex_d, 1'b1, 5'd4, mem_d, 1'b1);
        check_outputs(5'd3, 5'd4, 1'b1, 1'b0, 5'd4, 1'b1, d1, 32'h0000_00a5,
                      alu_pkg::ALUOP_OR, alu_pkg::SEL_LOGIC);
    endtask

    task automatic move_case(isa_pkg::funct_t fn, alu_pkg::aluop_t op, logic [31:0] rs_data,
                             logic ex_e, logic mem_e, logic [31:0] fwd_data, logic exp_wen);
        logic [31:0] d2;
        logic [31:0] exp_op1;
        d2 = $urandom;
        exp_op1 = (ex_e || mem_e) ? fwd_data : rs_data;
        apply_inputs(r_format(isa_pkg::OP_SPECIAL, 5'd6, 5'd7, 5'd8, 5'd0, fn), rs_data, d2,
                     5'd6, fwd_data, ex_e, 5'd6, fwd_data, mem_e);
        check_outputs(5'd6, 5'd7, 1'b1, 1'b1, 5'd8, exp_wen, exp_op1, d2, op,
                      alu_pkg::SEL_MOVE);
    endtask

    task automatic invalid_case(logic [31:0] inst);
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = $urandom;
        d2 = $urandom;
        apply_without_forwarding(inst, d1, d2);
        check_outputs(inst[25:21], inst[20:16], 1'b0, 1'b0, inst[15:11], 1'b0, '0, '0,
                      alu_pkg::ALUOP_NOP, alu_pkg::SEL_NOP);
    endtask

    initial begin
        logic [31:0] d2;
        void'($urandom(SEED));
        rst_n = 1'b0;
        inst_data = '0;
        reg_rd_data1 = '0;
        reg_rd_data2 = '0;
        ex_waddr = '0;
        ex_wdata = '0;
        ex_wen = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        mem_wen = 1'b0;

        reset_behavior(RESET_CYCLES);

        rtype_case(isa_pkg::FN_OR, alu_pkg::ALUOP_OR, alu_pkg::SEL_LOGIC);
        rtype_case(isa_pkg::FN_AND, alu_pkg::ALUOP_AND, alu_pkg::SEL_LOGIC);
        rtype_case(isa_pkg::FN_XOR, alu_pkg::ALUOP_XOR, alu_pkg::SEL_LOGIC);
        rtype_case(isa_pkg::FN_NOR, alu_pkg::ALUOP_NOR, alu_pkg::SEL_LOGIC);
        rtype_case(isa_pkg::FN_SLLV, alu_pkg::ALUOP_SLL, alu_pkg::SEL_SHIFT);
        rtype_case(isa_pkg::FN_SRLV, alu_pkg::ALUOP_SRL, alu_pkg::SEL_SHIFT);
        rtype_case(isa_pkg::FN_SRAV, alu_pkg::ALUOP_SRA, alu_pkg::SEL_SHIFT);

        imm_logic_case(isa_pkg::OP_ORI, alu_pkg::ALUOP_OR, 16'hbeef, 32'h0000_beef);
        imm_logic_case(isa_pkg::OP_ANDI, alu_pkg::ALUOP_AND, 16'h8001, 32'h0000_8001);
        imm_logic_case(isa_pkg::OP_XORI, alu_pkg::ALUOP_XOR, 16'h7f3c, 32'h0000_7f3c);
        imm_logic_case(isa_pkg::OP_LUI, alu_pkg::ALUOP_OR, 16'h1234, 32'h1234_0000);
        shift_imm_case(isa_pkg::FN_SLL, alu_pkg::ALUOP_SLL, 5'd31);
        shift_imm_case(isa_pkg::FN_SRL, alu_pkg::ALUOP_SRL, 5'd7);
        shift_imm_case(isa_pkg::FN_SRA, alu_pkg::ALUOP_SRA, 5'd16);

        forwarding_priority();

        move_case(isa_pkg::FN_MOVN, alu_pkg::ALUOP_MOVN, $urandom | 32'h1, 1'b0, 1'b0, '0, 1'b1);
        move_case(isa_pkg::FN_MOVN, alu_pkg::ALUOP_MOVN, '0, 1'b0, 1'b0, '0, 1'b0);
        move_case(isa_pkg::FN_MOVN, alu_pkg::ALUOP_MOVN, $urandom | 32'h1, 1'b1, 1'b0, '0, 1'b0);
        move_case(isa_pkg::FN_MOVN, alu_pkg::ALUOP_MOVN, '0, 1'b0, 1'b1, $urandom | 32'h1, 1'b1);
        move_case(isa_pkg::FN_MOVZ, alu_pkg::ALUOP_MOVZ, '0, 1'b0, 1'b0, '0, 1'b1);
        move_case(isa_pkg::FN_MOVZ, alu_pkg::ALUOP_MOVZ, $urandom | 32'h1, 1'b0, 1'b0, '0, 1'b0);
        move_case(isa_pkg::FN_MOVZ, alu_pkg::ALUOP_MOVZ, $urandom | 32'h1, 1'b0, 1'b1, '0, 1'b1);
        move_case(isa_pkg::FN_MOVZ, alu_pkg::ALUOP_MOVZ, '0, 1'b1, 1'b0, $urandom | 32'h1, 1'b0);

        invalid_case(r_format(6'd8, 5'd1, 5'd2, 5'd3, 5'd0, 6'd0));
        invalid_case(r_format(6'd35, 5'd10, 5'd11, 5'd12, 5'd0, 6'd0));
        invalid_case(r_format(isa_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'd32));
        invalid_case(r_format(isa_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd7, isa_pkg::FN_AND));
        invalid_case(r_format(isa_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd4, isa_pkg::FN_SLL));

        d2 = $urandom;
        apply_without_forwarding(r_format(isa_pkg::OP_SPECIAL, 5'd0, 5'd7, 5'd0, 5'd0,
                                          isa_pkg::FN_SYNC), $urandom, d2);
        check_outputs(5'd0, 5'd7, 1'b0, 1'b1, 5'd0, 1'b0, '0, d2, alu_pkg::ALUOP_NOP,
                      alu_pkg::SEL_NOP);
        apply_without_forwarding(i_format(isa_pkg::OP_PREF, 5'd8, 5'd3, 16'h0040), $urandom,
                                 $urandom);
        check_outputs(5'd8, 5'd3, 1'b0, 1'b0, 5'd3, 1'b0, '0, '0, alu_pkg::ALUOP_NOP,
                      alu_pkg::SEL_LOGIC);

        reset_behavior(2);                                      // Reset again in mid run

        $display("Done: no errors");
        $finish;
    end

endmodule
